// File: Makefile
# Verilator build and run of the command processor testbench

VERILATOR ?= verilator
TOP       ?= tb_cmd_processor
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_cmd_processor.sv
//----------------------------------------
// testbench for the command front end
// table of commands with expected replies,
// spi byte master and stream sink models
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_cmd_processor;
	import host_pkg::*;
	import periph_pkg::*;

	typedef struct packed {
		logic [63:0] cmd;	// byte 0 in the top bits
		logic        has_reply;
		word_t       reply;
		chip_sel_t   cs;	// expected during a transfer
	} row_t;

	localparam int ROWS = 10;
	localparam row_t TABLE [ROWS] = '{
		'{64'h0200_0000_0000_0000, 1'b1, 32'h0000_0009, 8'hff},
		'{64'h0100_0000_0000_0000, 1'b1, 32'h0000_0021, 8'hff},
		'{64'h0400_0000_0000_0000, 1'b1, 32'h0000_0013, 8'hff},
		'{64'h0305_813c_a700_0000, 1'b1, 32'h0000_00fd, 8'hdf},
		'{64'h0302_1122_3300_0002, 1'b1, 32'h0000_0078, 8'hfb},	// two bytes
		'{64'h0602_0301_0000_0000, 1'b0, 32'h0000_0000, 8'hff},
		'{64'h0900_0000_0000_0000, 1'b0, 32'h0000_0000, 8'hff},	// unknown
		'{64'h0200_0000_0000_0000, 1'b1, 32'h0000_0009, 8'hff},
		'{64'h0601_0500_0000_0000, 1'b0, 32'h0000_0000, 8'hff},
		'{64'h0307_f00f_5a00_0007, 1'b1, 32'h0000_0000, 8'h7f}
	};

	logic clk, rstn;
	logic i_rx_valid, o_rx_ready, i_tx_ready, o_tx_valid, o_tx_last;
	logic o_spi_tx_valid, i_spi_tx_ready, i_spi_rx_valid;
	logic o_pll_reset, o_phase_up, o_scanclk;
	byte_t i_rx_data, o_spi_tx_data, i_spi_rx_data;
	word_t o_tx_data;
	chip_sel_t o_spi_cs;
	counter_sel_t o_phase_counter_sel;
	phase_step_t o_phase_step;

	logic [31:0] lfsr;
	int value_errs, other_errs, pll_pulses, scan_toggles;
	word_t replies [$];
	byte_t spi_sent [$];
	chip_sel_t exp_cs;
	phase_step_t exp_step;

	cmd_processor i_cmd_processor (.*);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v = 2 * v + int'(lfsr[0]);
		end
		return v;
	endfunction

	task automatic compare_value(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			value_errs++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_other(input string what);
		other_errs++;
		$display("Error: %s", what);
	endtask

	task automatic run_command(input row_t row);
		byte_t op;
		int    n_spi;
		op       = row.cmd[63:56];
		exp_cs   = row.cs;
		exp_step = phase_step_t'(1) << row.cmd[49:48];
		replies.delete();
		spi_sent.delete();
		pll_pulses   = 0;
		scan_toggles = 0;
		for (int k = 7; k >= 0; k--) begin
			i_rx_valid = 1'b1;
			i_rx_data  = row.cmd[8*k +: 8];
			while (!o_rx_ready)
				@(negedge clk);
			@(negedge clk);	// byte taken
		end
		i_rx_valid = 1'b0;
		while (!o_rx_ready)
			@(negedge clk);	// command finished
		@(negedge clk);

		if (row.has_reply) begin
			assert (replies.size() == 1) else report_other("expected exactly one reply beat");
			if (replies.size() > 0)
				compare_value("o_tx_data", replies[0], row.reply);
		end else begin
			assert (replies.size() == 0) else report_other("reply beat for a silent command");
		end
		assert (pll_pulses == (op == 8'd1 ? 1 : 0)) else report_other("wrong o_pll_reset pulses");
		n_spi = (op != 8'd3) ? 0 : (row.cmd[7:0] == 8'd2) ? 2 : 3;
		assert (spi_sent.size() == n_spi) else report_other("wrong number of spi bytes sent");
		for (int k = 0; k < n_spi && k < spi_sent.size(); k++)
			compare_value("o_spi_tx_data", 32'(spi_sent[k]), 32'(row.cmd[47-8*k -: 8]));
		compare_value("o_spi_cs", 32'(o_spi_cs), 32'hff);
		if (op == 8'd6) begin
			assert (scan_toggles == SCAN_TOGGLES) else report_other("wrong scanclk toggle count");
			compare_value("o_phase_counter_sel", 32'(o_phase_counter_sel), 32'(row.cmd[42:40]));
			compare_value("o_phase_up", 32'(o_phase_up), 32'(row.cmd[32]));
		end else begin
			assert (scan_toggles == 0) else report_other("scanclk moved without a phase command");
		end
		compare_value("o_phase_step", 32'(o_phase_step), 32'h0);
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//----------------------------------------
	// spi byte master and stream sink
	initial begin : bus_models
		int    spi_wait;
		logic  hold_pending;
		word_t held_data;
		logic  prev_scanclk;
		byte_t sent;
		i_tx_ready     = 1'b0;
		i_spi_tx_ready = 1'b0;
		i_spi_rx_valid = 1'b0;
		i_spi_rx_data  = '0;
		spi_wait       = 0;
		hold_pending   = 1'b0;
		held_data      = '0;
		prev_scanclk   = 1'b0;
		sent           = '0;
		forever begin
			@(negedge clk);
			if (hold_pending) begin
				assert (o_tx_valid) else report_other("reply withdrawn under back-pressure");
				compare_value("o_tx_data", o_tx_data, held_data);
			end
			i_tx_ready = (take_bits(2) != 0);	// ready 3 of 4
			if (o_tx_valid && i_tx_ready) begin
				replies.push_back(o_tx_data);
				assert (o_tx_last) else report_other("o_tx_last low on a reply beat");
			end
			hold_pending = o_tx_valid && !i_tx_ready;
			held_data    = o_tx_data;

			i_spi_rx_valid = 1'b0;
			if (i_spi_tx_ready) begin	// byte went out last edge
				i_spi_tx_ready = 1'b0;
				i_spi_rx_valid = 1'b1;
				i_spi_rx_data  = sent ^ 8'h5a;
			end else if (o_spi_tx_valid) begin
				if (spi_wait == 0) begin
					sent = o_spi_tx_data;
					spi_sent.push_back(sent);
					compare_value("o_spi_cs", 32'(o_spi_cs), 32'(exp_cs));
					i_spi_tx_ready = 1'b1;
					spi_wait = take_bits(2);
				end else begin
					spi_wait--;
				end
			end

			if (o_pll_reset)
				pll_pulses++;
			if (o_scanclk != prev_scanclk) begin
				compare_value("o_phase_step", 32'(o_phase_step),
					(scan_toggles < STEP_RELEASE - 1) ? 32'(exp_step) : 32'h0);	// low from release on
				scan_toggles++;
			end
			prev_scanclk = o_scanclk;
		end
	end

	initial begin : watchdog
		repeat (ROWS * 400 + 20) @(posedge clk);
		$display("Error: timeout, a command never finished");
		$display("test failed");
		$finish;
	end

	initial begin : run_tests
		lfsr       = 32'h30c;
		value_errs = 0;
		other_errs = 0;
		rstn       = 1'b0;
		i_rx_valid = 1'b0;
		i_rx_data  = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		compare_value("o_tx_valid", 32'(o_tx_valid), 32'h0);
		compare_value("o_spi_tx_valid", 32'(o_spi_tx_valid), 32'h0);
		compare_value("o_pll_reset", 32'(o_pll_reset), 32'h0);
		compare_value("o_phase_step", 32'(o_phase_step), 32'h0);
		compare_value("o_scanclk", 32'(o_scanclk), 32'h0);
		compare_value("o_spi_cs", 32'(o_spi_cs), 32'hff);
		rstn = 1'b1;
		@(negedge clk);
		for (int r = 0; r < ROWS; r++)
			run_command(TABLE[r]);
		$display("errors: %0d wrong values, %0d other", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
verilog/host_pkg.sv
verilog/periph_pkg.sv
verilog/cmd_ifs.sv
verilog/cmd_decoder.sv
verilog/spi_sequencer.sv
verilog/phase_stepper.sv
verilog/reply_streamer.sv
verilog/cmd_processor.sv
sim/tb_cmd_processor.sv

// File: verilog/cmd_decoder.sv
//----------------------------------------
// command decoder
// collects 8 host bytes, runs the command
// by opcode and waits until it finishes
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
	input  logic            clk,
	input  logic            rstn,
	input  logic            i_rx_valid,
	output logic            o_rx_ready,
	input  host_pkg::byte_t i_rx_data,
	output logic            o_pll_reset,
	spi_req_if.master       spi,
	phase_req_if.master     phase,
	output logic            o_const_valid,
	input  logic            i_const_ready,
	output host_pkg::word_t o_const_word,
	input  logic            i_reply_sent
);
	import host_pkg::*;

	typedef enum logic [1:0] {RECEIVE, DISPATCH, WAIT_REPLY, WAIT_PHASE} state_e;

	state_e    state;
	byte_idx_t rx_cnt;
	byte_t     cmd [CMD_BYTES];
	opcode_e   opcode;

	assign o_rx_ready = (state == RECEIVE);
	assign opcode     = opcode_e'(cmd[0]);

	always_ff @(posedge clk) begin
		if (i_rx_valid && o_rx_ready)
			cmd[rx_cnt] <= i_rx_data;
	end

	// request fields straight from the stored bytes
	assign spi.chip          = cmd[1][2:0];
	assign spi.tx0           = cmd[2];
	assign spi.tx1           = cmd[3];
	assign spi.tx2           = cmd[4];
	assign spi.three_bytes   = (cmd[7] != 8'd2);
	assign phase.step_idx    = cmd[1][1:0];
	assign phase.counter_sel = cmd[2][2:0];
	assign phase.up          = cmd[3][0];

	always_comb begin
		case (opcode)
			OP_PLL_RESET: o_const_word = PLL_RESET_ACK;
			OP_VERSION:   o_const_word = FW_VERSION;
			default:      o_const_word = SPARE_ACK;
		endcase
	end

	//----------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state         <= RECEIVE;
			rx_cnt        <= '0;
			o_pll_reset   <= 1'b0;
			o_const_valid <= 1'b0;
			spi.valid     <= 1'b0;
			phase.valid   <= 1'b0;
		end else begin
			o_pll_reset <= 1'b0;
			case (state)
				RECEIVE: if (i_rx_valid) begin
					rx_cnt <= rx_cnt + 1'b1;	// wraps after last byte
					if (rx_cnt == LAST_BYTE)
						state <= DISPATCH;
				end
				DISPATCH: begin
					state <= WAIT_REPLY;
					case (opcode)
						OP_PLL_RESET: begin
							o_pll_reset   <= 1'b1;
							o_const_valid <= 1'b1;
						end
						OP_VERSION, OP_SPARE: o_const_valid <= 1'b1;
						OP_SPI:               spi.valid <= 1'b1;
						OP_PHASE: begin
							phase.valid <= 1'b1;
							state       <= WAIT_PHASE;
						end
						default: state <= RECEIVE;	// unknown, ignore
					endcase
				end
				WAIT_REPLY: begin
					if (spi.valid && spi.ready)
						spi.valid <= 1'b0;
					if (o_const_valid && i_const_ready)
						o_const_valid <= 1'b0;
					if (i_reply_sent)
						state <= RECEIVE;
				end
				WAIT_PHASE: if (phase.ready) begin
					if (phase.valid)
						phase.valid <= 1'b0;	// taken
					else
						state <= RECEIVE;	// stepper done
				end
				default: state <= RECEIVE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/cmd_ifs.sv
//----------------------------------------
// request interfaces from the decoder to
// the spi sequencer and phase stepper
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface spi_req_if;
	import host_pkg::*;
	import periph_pkg::*;

	logic  valid;
	logic  ready;
	chip_t chip;
	byte_t tx0;
	byte_t tx1;
	byte_t tx2;
	logic  three_bytes;	// else only tx0 and tx1

	modport master (output valid, chip, tx0, tx1, tx2, three_bytes, input ready);
	modport slave  (input valid, chip, tx0, tx1, tx2, three_bytes, output ready);
endinterface

interface phase_req_if;
	import periph_pkg::*;

	logic         valid;
	logic         ready;
	counter_sel_t counter_sel;
	logic         up;
	step_idx_t    step_idx;	// which step line

	modport master (output valid, counter_sel, up, step_idx, input ready);
	modport slave  (input valid, counter_sel, up, step_idx, output ready);
endinterface

`default_nettype wire

// File: verilog/cmd_processor.sv
//----------------------------------------
// host command front end, top level
// byte stream in, reply words out, spi
// master and pll phase controls
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cmd_processor (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     i_rx_valid,
	output logic                     o_rx_ready,
	input  host_pkg::byte_t          i_rx_data,
	output logic                     o_tx_valid,
	input  logic                     i_tx_ready,
	output host_pkg::word_t          o_tx_data,
	output logic                     o_tx_last,
	output logic                     o_spi_tx_valid,
	input  logic                     i_spi_tx_ready,
	output host_pkg::byte_t          o_spi_tx_data,
	input  logic                     i_spi_rx_valid,
	input  host_pkg::byte_t          i_spi_rx_data,
	output periph_pkg::chip_sel_t    o_spi_cs,
	output logic                     o_pll_reset,
	output periph_pkg::counter_sel_t o_phase_counter_sel,
	output logic                     o_phase_up,
	output periph_pkg::phase_step_t  o_phase_step,
	output logic                     o_scanclk
);
	import host_pkg::*;

	logic  const_valid;
	logic  const_ready;
	word_t const_word;
	logic  spi_valid;
	logic  spi_ready;
	byte_t spi_byte;
	logic  reply_sent;

	spi_req_if   spi_req ();
	phase_req_if phase_req ();

	cmd_decoder i_cmd_decoder (
		.clk, .rstn, .i_rx_valid, .o_rx_ready, .i_rx_data, .o_pll_reset,
		.spi(spi_req.master), .phase(phase_req.master),
		.o_const_valid(const_valid), .i_const_ready(const_ready),
		.o_const_word(const_word), .i_reply_sent(reply_sent)
	);

	spi_sequencer i_spi_sequencer (
		.clk, .rstn, .req(spi_req.slave),
		.o_spi_tx_valid, .i_spi_tx_ready, .o_spi_tx_data,
		.i_spi_rx_valid, .i_spi_rx_data, .o_spi_cs,
		.o_reply_valid(spi_valid), .i_reply_ready(spi_ready), .o_reply_byte(spi_byte)
	);

	phase_stepper i_phase_stepper (
		.clk, .rstn, .req(phase_req.slave),
		.o_counter_sel(o_phase_counter_sel), .o_up(o_phase_up),
		.o_phase_step, .o_scanclk
	);

	reply_streamer i_reply_streamer (
		.clk, .rstn,
		.i_const_valid(const_valid), .o_const_ready(const_ready), .i_const_word(const_word),
		.i_spi_valid(spi_valid), .o_spi_ready(spi_ready), .i_spi_byte(spi_byte),
		.o_tx_valid, .i_tx_ready, .o_tx_data, .o_tx_last, .o_reply_sent(reply_sent)
	);

endmodule

`default_nettype wire

// File: verilog/host_pkg.sv
//----------------------------------------
// host protocol definitions
// command bytes, reply words, opcodes and
// the constant replies of the front end
//----------------------------------------
`default_nettype none

package host_pkg;

	typedef logic [7:0]  byte_t;	// command or spi byte
	typedef logic [31:0] word_t;	// reply word

	typedef enum logic [7:0] {
		OP_PLL_RESET = 8'd1,
		OP_VERSION   = 8'd2,
		OP_SPI       = 8'd3,
		OP_SPARE     = 8'd4,
		OP_PHASE     = 8'd6
	} opcode_e;

	localparam int CMD_BYTES = 8;	// bytes per command

	typedef logic [$clog2(CMD_BYTES)-1:0] byte_idx_t;
	localparam byte_idx_t LAST_BYTE = byte_idx_t'(CMD_BYTES - 1);

	localparam word_t FW_VERSION    = 32'd9;
	localparam word_t PLL_RESET_ACK = 32'd33;
	localparam word_t SPARE_ACK     = 32'd19;

endpackage

`default_nettype wire

// File: verilog/periph_pkg.sv
//----------------------------------------
// board peripheral definitions
// spi chip selects and pll phase stepping
//----------------------------------------
`default_nettype none

package periph_pkg;

	typedef logic [2:0] chip_t;		// chip index
	typedef logic [7:0] chip_sel_t;		// active low selects
	typedef logic [2:0] counter_sel_t;	// 000 all, 001 M, 010 C0 ...
	typedef logic [3:0] phase_step_t;	// one-hot step lines

	typedef logic [$clog2($bits(phase_step_t))-1:0] step_idx_t;

	localparam int SCAN_HALF    = 16;	// clk cycles per half period
	localparam int SCAN_TOGGLES = 8;
	localparam int STEP_RELEASE = 6;	// step drops at this toggle

	typedef logic [$clog2(SCAN_HALF)-1:0]      half_cnt_t;
	typedef logic [$clog2(SCAN_TOGGLES+1)-1:0] toggle_cnt_t;

endpackage

`default_nettype wire

// File: verilog/phase_stepper.sv
//----------------------------------------
// pll phase stepper
// holds counter select and direction,
// raises one step line and clocks scanclk
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module phase_stepper (
	input  logic                     clk,
	input  logic                     rstn,
	phase_req_if.slave               req,
	output periph_pkg::counter_sel_t o_counter_sel,
	output logic                     o_up,
	output periph_pkg::phase_step_t  o_phase_step,
	output logic                     o_scanclk
);
	import periph_pkg::*;

	typedef enum logic {IDLE, RUN} state_e;

	state_e      state;
	half_cnt_t   half_cnt;
	toggle_cnt_t toggles;

	assign req.ready = (state == IDLE);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state         <= IDLE;
			half_cnt      <= '0;
			toggles       <= '0;
			o_counter_sel <= '0;
			o_up          <= 1'b1;	// up by default
			o_phase_step  <= '0;
			o_scanclk     <= 1'b0;
		end else begin
			case (state)
				IDLE: if (req.valid) begin
					o_counter_sel <= req.counter_sel;
					o_up          <= req.up;
					o_phase_step  <= phase_step_t'(1) << req.step_idx;
					half_cnt      <= '0;
					toggles       <= '0;
					o_scanclk     <= 1'b0;	// start low
					state         <= RUN;
				end
				RUN: if (half_cnt == half_cnt_t'(SCAN_HALF - 1)) begin
					half_cnt  <= '0;
					o_scanclk <= ~o_scanclk;
					toggles   <= toggles + 1'b1;
					if (toggles == toggle_cnt_t'(STEP_RELEASE - 1))
						o_phase_step <= '0;
					if (toggles == toggle_cnt_t'(SCAN_TOGGLES - 1))
						state <= IDLE;
				end else begin
					half_cnt <= half_cnt + 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/reply_streamer.sv
//----------------------------------------
// reply streamer
// one-entry register that sends a reply
// word as a single beat, spi read first
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module reply_streamer (
	input  logic            clk,
	input  logic            rstn,
	input  logic            i_const_valid,
	output logic            o_const_ready,
	input  host_pkg::word_t i_const_word,
	input  logic            i_spi_valid,
	output logic            o_spi_ready,
	input  host_pkg::byte_t i_spi_byte,
	output logic            o_tx_valid,
	input  logic            i_tx_ready,
	output host_pkg::word_t o_tx_data,
	output logic            o_tx_last,
	output logic            o_reply_sent
);
	import host_pkg::*;

	assign o_spi_ready   = !o_tx_valid;
	assign o_const_ready = !o_tx_valid && !i_spi_valid;
	assign o_tx_last     = 1'b1;	// every reply is one beat
	assign o_reply_sent  = o_tx_valid && i_tx_ready;

	always_ff @(posedge clk) begin
		if (o_spi_ready && i_spi_valid)
			o_tx_data <= word_t'(i_spi_byte);	// zero extend
		else if (o_const_ready && i_const_valid)
			o_tx_data <= i_const_word;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			o_tx_valid <= 1'b0;
		else if (o_tx_valid)
			o_tx_valid <= !i_tx_ready;	// hold under back-pressure
		else
			o_tx_valid <= i_spi_valid || i_const_valid;
	end

endmodule

`default_nettype wire

// File: verilog/spi_sequencer.sv
//----------------------------------------
// spi sequencer
// selects a chip, sends two or three bytes
// to the spi byte master and returns the
// byte read back after the last one
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spi_sequencer (
	input  logic                  clk,
	input  logic                  rstn,
	spi_req_if.slave              req,
	output logic                  o_spi_tx_valid,
	input  logic                  i_spi_tx_ready,
	output host_pkg::byte_t       o_spi_tx_data,
	input  logic                  i_spi_rx_valid,
	input  host_pkg::byte_t       i_spi_rx_data,
	output periph_pkg::chip_sel_t o_spi_cs,
	output logic                  o_reply_valid,
	input  logic                  i_reply_ready,
	output host_pkg::byte_t       o_reply_byte
);
	import host_pkg::*;
	import periph_pkg::*;

	typedef enum logic [1:0] {IDLE, SEND, WAIT_RX, REPLY} state_e;

	state_e     state;
	byte_t      tx_buf [3];
	logic [1:0] byte_idx;
	logic [1:0] last_idx;

	assign req.ready      = (state == IDLE);
	assign o_spi_tx_valid = (state == SEND);
	assign o_spi_tx_data  = tx_buf[byte_idx];
	assign o_reply_valid  = (state == REPLY);

	always_ff @(posedge clk) begin
		if (req.valid && req.ready) begin
			tx_buf[0] <= req.tx0;
			tx_buf[1] <= req.tx1;
			tx_buf[2] <= req.tx2;
		end
		if (state == WAIT_RX && i_spi_rx_valid)
			o_reply_byte <= i_spi_rx_data;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state    <= IDLE;
			byte_idx <= '0;
			last_idx <= '0;
			o_spi_cs <= '1;	// nothing selected
		end else begin
			case (state)
				IDLE: if (req.valid) begin
					byte_idx <= '0;
					last_idx <= req.three_bytes ? 2'd2 : 2'd1;
					o_spi_cs <= ~(chip_sel_t'(1) << req.chip);
					state    <= SEND;
				end
				SEND: if (i_spi_tx_ready) begin
					if (byte_idx == last_idx)
						state <= WAIT_RX;
					else
						byte_idx <= byte_idx + 1'b1;
				end
				WAIT_RX: if (i_spi_rx_valid) begin	// read of final byte
					o_spi_cs <= '1;
					state    <= REPLY;
				end
				REPLY: if (i_reply_ready)
					state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire
